//--- common/cen_config.svh
`ifndef CEN_CONFIG_SVH
`define CEN_CONFIG_SVH

// Accumulator width of every fractional divider
`define CEN_WC 16

// clk domain, 50.3496 MHz
`define PXL_N 1                          // Pixel 2x, 12.59 MHz
`define PXL_M 4

`define CPU_N 29                         // Main CPU, 10.0 MHz
`define CPU_M 146

// clk_snd domain, 25.1748 MHz
`define MCU_N 143                        // Sound MCU, 8.0 MHz
`define MCU_M 450

`define FM_N 143                         // FM chip, 4.0 MHz
`define FM_M 900

`define SND_N 1373                       // Sound CPU, 5.0 MHz
`define SND_M 6913

// PCM on board A, 6.0 MHz
`define PCMA_N 1619
`define PCMA_M 6793

// PCM on board B, 640 kHz
`define PCMB_N 873
`define PCMB_M 34340

`endif

//--- common/board_pkg.sv
package board_pkg;

    // Board variant, picks the PCM rate
    typedef enum logic {
        BOARD_A = 1'b0,                  // PCM near 6 MHz
        BOARD_B = 1'b1                   // PCM at 640 kHz
    } board_e;

    // Main CPU enable source
    typedef enum logic {
        CPU_FRAC = 1'b0,                 // Fractional 29/146 of clk, about 10 MHz
        CPU_FAST = 1'b1                  // Plain toggle, half of clk
    } cpu_mode_e;

endpackage

//--- common/cen_pkg.sv
package cen_pkg;

    // Ratio word for the fractional divider
    // Must hold the largest m in use, 34340 for the slow PCM rate
    typedef logic [15:0] frac_t;

    // One entry per enable output of the top level
    typedef enum logic [3:0] {
        PXL2 = 4'd0,                     // Pixel 2x, clk domain
        PXL  = 4'd1,                     // Pixel 1x, half of PXL2
        CPU  = 4'd2,                     // Main CPU
        CPUB = 4'd3,                     // Main CPU, opposite phase
        MCU  = 4'd4,                     // Sound MCU, clk_snd domain
        SND  = 4'd5,                     // Sound CPU
        FM   = 4'd6,                     // FM chip
        FM2  = 4'd7,                     // FM half rate
        PCM  = 4'd8,                     // PCM, rate set by board
        PCMB = 4'd9                      // PCM opposite phase
    } cen_id_e;

endpackage

//--- logic/frac_cen.sv
`timescale 1ns/1ps

// Fractional enable generator, base rate n/m of clk
// n must not exceed m/2 or half-phase pulses get lost
module frac_cen import cen_pkg::*; #(
    parameter int W  = 2,                // Sub-rate outputs, cen[k] at 1/2^k of base
    parameter int WC = 16                // Accumulator width
) (
    input  logic         clk,
    input  logic         rst_n,          // Sync, active low
    input  frac_t        n,              // Step added each cycle
    input  frac_t        m,              // Wrap point
    output logic [W-1:0] cen,            // Base pulse and sub-rates
    output logic [W-1:0] cenb            // Opposite-phase companions
);

    logic [WC-1:0] acc;                  // Fractional accumulator
    logic [WC:0]   sum;                  // acc + n, one bit of headroom
    logic [WC:0]   m_ext;
    logic          hit;                  // Sum reached m
    logic          half;                 // Sum reached m/2
    logic          armed;                // Half crossing owed since last base pulse
    logic          fire_b;               // Opposite pulse this cycle
    logic [W-1:0]  cnt;                  // Base pulse counter, wraps
    logic [W-1:0]  cnt_last;             // Index of latest base pulse
    logic [W-1:0]  sub_hit;              // Sub-rate k due on next base pulse
    logic [W-1:0]  subb_hit;             // Sub-rate k due on next opposite pulse

    // Low k bits set
    function automatic logic [W-1:0] low_mask(input int k);
        low_mask = (W'(1) << k) - W'(1);
    endfunction

    always_comb begin
        m_ext    = (WC+1)'(m);
        sum      = {1'b0, acc} + (WC+1)'(n);
        hit      = sum >= m_ext;
        half     = {sum, 1'b0} >= {1'b0, m_ext}; // 2*sum >= m, no rounding
        fire_b   = armed && half && !hit;
        cnt_last = cnt - W'(1);          // cnt already moved past the last base pulse
        for (int k = 0; k < W; k++) begin
            sub_hit[k]  = (cnt & low_mask(k)) == '0;      // Every 2^k-th, first included
            subb_hit[k] = (cnt_last & low_mask(k)) == '0; // Follows matching cen[k]
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            acc   <= '0;
            cnt   <= '0;
            armed <= 1'b0;               // First event is a base pulse
            cen   <= '0;
            cenb  <= '0;
        end else begin
            if (hit) begin
                acc <= WC'(sum - m_ext); // Keep the remainder
            end else begin
                acc <= WC'(sum);
            end
            cen  <= {W{hit}} & sub_hit;  // Registered, one cycle wide
            cenb <= {W{fire_b}} & subb_hit;
            if (hit) begin
                cnt   <= cnt + W'(1);
                armed <= 1'b1;           // Next half crossing is owed
            end else if (fire_b) begin
                armed <= 1'b0;
            end
        end
    end

endmodule

//--- logic/s16_cen.sv
`timescale 1ns/1ps

`include "cen_config.svh"

// Clock enables of the system board
// clk is 50.3496 MHz for video and main CPU, clk_snd is 25.1748 MHz for sound
module s16_cen import board_pkg::*, cen_pkg::*; #(
    parameter board_e    BOARD    = BOARD_A,  // PCM rate choice
    parameter cpu_mode_e CPU_MODE = CPU_FRAC  // Fractional or toggle CPU enable
) (
    input  logic clk,                    // Video and CPU clock
    input  logic clk_snd,                // Sound clock
    input  logic rst_n,                  // Sync, must span a clk_snd edge

    output logic pxl2_cen,               // Pixel 2x, 12.59 MHz
    output logic pxl_cen,                // Pixel 1x, 6.29 MHz
    output logic cpu_cen,                // 10 MHz, or clk/2 in fast mode
    output logic cpu_cenb,

    output logic mcu_cen,                // 8 MHz
    output logic snd_cen,                // 5 MHz
    output logic fm_cen,                 // 4 MHz
    output logic fm2_cen,                // 2 MHz
    output logic pcm_cen,                // 6 MHz or 640 kHz
    output logic pcm_cenb
);

    // clk domain

    frac_cen #(
        .W      (2),
        .WC     (`CEN_WC)
    ) u_pxl_cen (
        .clk    (clk),
        .rst_n  (rst_n),
        .n      (frac_t'(`PXL_N)),
        .m      (frac_t'(`PXL_M)),
        .cen    ({pxl_cen, pxl2_cen}),   // Bit 1 is half rate
        .cenb   ()
    );

    generate
        if (CPU_MODE == CPU_FAST) begin : g_cpu_fast
            logic fast_q;                // Toggles every cycle

            always_ff @(posedge clk) begin
                if (!rst_n) begin
                    fast_q <= 1'b0;      // cpu_cen starts low
                end else begin
                    fast_q <= ~fast_q;
                end
            end

            assign cpu_cen  = fast_q;
            assign cpu_cenb = ~fast_q;   // High during reset
        end else begin : g_cpu_frac
            frac_cen #(
                .W      (1),
                .WC     (`CEN_WC)
            ) u_cpu_cen (
                .clk    (clk),
                .rst_n  (rst_n),
                .n      (frac_t'(`CPU_N)),
                .m      (frac_t'(`CPU_M)),
                .cen    (cpu_cen),
                .cenb   (cpu_cenb)       // Mid-period companion
            );
        end
    endgenerate

    // clk_snd domain

    frac_cen #(
        .W      (1),
        .WC     (`CEN_WC)
    ) u_mcu_cen (
        .clk    (clk_snd),
        .rst_n  (rst_n),
        .n      (frac_t'(`MCU_N)),
        .m      (frac_t'(`MCU_M)),
        .cen    (mcu_cen),
        .cenb   ()
    );

    frac_cen #(
        .W      (2),
        .WC     (`CEN_WC)
    ) u_fm_cen (
        .clk    (clk_snd),
        .rst_n  (rst_n),
        .n      (frac_t'(`FM_N)),
        .m      (frac_t'(`FM_M)),
        .cen    ({fm2_cen, fm_cen}),     // fm2 on every other fm pulse
        .cenb   ()
    );

    frac_cen #(
        .W      (1),
        .WC     (`CEN_WC)
    ) u_snd_cen (
        .clk    (clk_snd),
        .rst_n  (rst_n),
        .n      (frac_t'(`SND_N)),
        .m      (frac_t'(`SND_M)),
        .cen    (snd_cen),
        .cenb   ()
    );

    generate
        if (BOARD == BOARD_B) begin : g_pcm_b
            frac_cen #(
                .W      (1),
                .WC     (`CEN_WC)        // m of 34340 needs all 16 bits
            ) u_pcm_cen (
                .clk    (clk_snd),
                .rst_n  (rst_n),
                .n      (frac_t'(`PCMB_N)),
                .m      (frac_t'(`PCMB_M)),
                .cen    (pcm_cen),
                .cenb   (pcm_cenb)
            );
        end else begin : g_pcm_a
            frac_cen #(
                .W      (1),
                .WC     (`CEN_WC)
            ) u_pcm_cen (
                .clk    (clk_snd),
                .rst_n  (rst_n),
                .n      (frac_t'(`PCMA_N)),
                .m      (frac_t'(`PCMA_M)),
                .cen    (pcm_cen),
                .cenb   (pcm_cenb)
            );
        end
    endgenerate

endmodule

//--- test/cen_checker.sv
`timescale 1ns/1ps

`include "cen_config.svh"

// Watches the enable outputs and checks rates, sub-rates, phase and width
module cen_checker import board_pkg::*, cen_pkg::*; #(
    parameter cpu_mode_e CPU_MODE = CPU_FRAC
) (
    input  logic clk, clk_snd, rst_n,
    input  logic pxl2_cen, pxl_cen, cpu_cen, cpu_cenb, mcu_cen,
    input  logic snd_cen, fm_cen, fm2_cen, pcm_cen, pcm_cenb,
    input  logic start,                  // Begin one rate window
    input  cen_id_e id,                  // Output under test
    input  logic snd_dom,                // Window counted in clk_snd cycles
    input  frac_t n, m,
    input  int k, win,
    output int tests_done, pass_cnt, fail_cnt, err_cnt
);

    logic sel;                           // Output picked by id
    logic rst_q, rst_sq;                 // Reset seen at previous edge
    logic pxl2_q, pxl_q, cpu_q, cpub_q;
    logic mcu_q, snd_q, fm_q, fm2_q, pcm_q, pcmb_q;
    int   pxl_par, fm_par;               // Base pulse parity for sub-rates
    int   cpu_last, pcm_last;            // 0 none, 1 base, 2 opposite
    int   clk_errs = 0;                  // Rule violations in clk domain
    int   snd_errs = 0;                  // Rule violations in clk_snd domain

    assign err_cnt = clk_errs + snd_errs;

    always_comb begin
        case (id)
            PXL2: sel = pxl2_cen;
            PXL:  sel = pxl_cen;
            CPU:  sel = cpu_cen;
            CPUB: sel = cpu_cenb;
            MCU:  sel = mcu_cen;
            SND:  sel = snd_cen;
            FM:   sel = fm_cen;
            FM2:  sel = fm2_cen;
            PCM:  sel = pcm_cen;
            default: sel = pcm_cenb;
        endcase
    end

    task automatic clk_fault(input string what);
        clk_errs++;
        $display("Check failed: %s at %0t ns", what, $time);
    endtask

    task automatic snd_fault(input string what);
        snd_errs++;
        $display("Check failed: %s at %0t ns", what, $time);
    endtask

    // Count pulses of the selected output over the window
    initial begin
        int     got;
        int     exp;
        longint fl;
        tests_done = 0;
        pass_cnt = 0;
        fail_cnt = 0;
        forever begin
            @(posedge start);
            got = 0;
            for (int c = 0; c < win; c++) begin
                if (snd_dom) @(posedge clk_snd);
                else @(posedge clk);
                if (sel) got++;
            end
            fl  = (longint'(win) * longint'(n)) / longint'(m); // Base pulses
            exp = int'((fl + (longint'(1) << k) - 1) >> k);    // Sub-rate, rounded up
            if (got + 1 >= exp && got <= exp + 1) begin
                pass_cnt++;
                $display("Test %0d %s: ok, %0d pulses", tests_done, id.name(), got);
            end else begin
                fail_cnt++;
                $display("** Error: %s count got 0x%0h expected 0x%0h",
                         id.name(), got, exp);
            end
            tests_done++;
        end
    end

    // clk domain
    always @(posedge clk) begin
        if (!rst_q) begin                // Reset values still showing
            if (pxl2_cen || pxl_cen || cpu_cen) clk_fault("clk enable high in reset");
            if (cpu_cenb != (CPU_MODE == CPU_FAST)) clk_fault("cpu_cenb wrong in reset");
        end else begin
            if (pxl2_cen && pxl2_q) clk_fault("pxl2_cen wider than one cycle");
            if (pxl_cen && pxl_q) clk_fault("pxl_cen wider than one cycle");
            if (pxl_cen && !pxl2_cen) clk_fault("pxl_cen without pxl2_cen");
            if (pxl2_cen && (pxl_cen != (pxl_par % 2 == 0)))
                clk_fault("pxl_cen sub-rate wrong");
            if (pxl2_cen) pxl_par++;
            if (CPU_MODE == CPU_FAST) begin
                if (cpu_cen == cpu_q) clk_fault("cpu_cen did not toggle");
                if (cpu_cenb == cpu_cen) clk_fault("cpu_cenb not the inverse of cpu_cen");
            end else begin
                if (cpu_cen && cpu_q) clk_fault("cpu_cen wider than one cycle");
                if (cpu_cenb && cpub_q) clk_fault("cpu_cenb wider than one cycle");
                if (cpu_cen && cpu_cenb) clk_fault("cpu_cen and cpu_cenb together");
                if (cpu_cen && cpu_last == 1) clk_fault("two cpu_cen without cpu_cenb");
                if (cpu_cenb && cpu_last != 1) clk_fault("cpu_cenb without cpu_cen before");
                if (cpu_cen) cpu_last = 1;
                if (cpu_cenb) cpu_last = 2;
            end
        end
        if (!rst_n) begin
            pxl_par = 0;
            cpu_last = 0;
        end
        rst_q  <= rst_n;
        pxl2_q <= pxl2_cen;
        pxl_q  <= pxl_cen;
        cpu_q  <= cpu_cen;
        cpub_q <= cpu_cenb;
    end

    // clk_snd domain
    always @(posedge clk_snd) begin
        if (!rst_sq) begin
            if (mcu_cen || snd_cen || fm_cen || fm2_cen || pcm_cen || pcm_cenb)
                snd_fault("sound enable high in reset");
        end else begin
            if ((mcu_cen && mcu_q) || (snd_cen && snd_q) || (fm_cen && fm_q) ||
                (fm2_cen && fm2_q) || (pcm_cen && pcm_q) || (pcm_cenb && pcmb_q))
                snd_fault("sound enable wider than one cycle");
            if (fm2_cen && !fm_cen) snd_fault("fm2_cen without fm_cen");
            if (fm_cen && (fm2_cen != (fm_par % 2 == 0))) snd_fault("fm2_cen sub-rate wrong");
            if (fm_cen) fm_par++;
            if (pcm_cen && pcm_cenb) snd_fault("pcm_cen and pcm_cenb together");
            if (pcm_cen && pcm_last == 1) snd_fault("two pcm_cen without pcm_cenb");
            if (pcm_cenb && pcm_last != 1) snd_fault("pcm_cenb without pcm_cen before");
            if (pcm_cen) pcm_last = 1;
            if (pcm_cenb) pcm_last = 2;
        end
        if (!rst_n) begin
            fm_par = 0;
            pcm_last = 0;
        end
        rst_sq <= rst_n;
        mcu_q  <= mcu_cen;
        snd_q  <= snd_cen;
        fm_q   <= fm_cen;
        fm2_q  <= fm2_cen;
        pcm_q  <= pcm_cen;
        pcmb_q <= pcm_cenb;
    end

endmodule

//--- test/tb_s16_cen.sv
`timescale 1ns/1ps

`include "cen_config.svh"

module tb_s16_cen import board_pkg::*, cen_pkg::*; #(
    parameter int BOARD    = 0,          // 0 board A, 1 board B
    parameter int CPU_MODE = 0           // 0 fractional, 1 fast toggle
) ();

    localparam board_e    BOARD_V = BOARD[0] ? BOARD_B : BOARD_A;
    localparam cpu_mode_e MODE_V  = CPU_MODE[0] ? CPU_FAST : CPU_FRAC;
    localparam int        NROW    = 10;

    logic clk, clk_snd, rst_n;
    logic pxl2_cen, pxl_cen, cpu_cen, cpu_cenb, mcu_cen;
    logic snd_cen, fm_cen, fm2_cen, pcm_cen, pcm_cenb;
    logic    start, snd_dom;
    cen_id_e id;
    frac_t   n, m;
    int      k, win;
    int      tests_done, pass_cnt, fail_cnt, err_cnt;
    int      cyc, limit;

    // Stimulus table, one row per enable output
    cen_id_e row_id[NROW];
    logic    row_snd[NROW];
    frac_t   row_n[NROW], row_m[NROW];
    int      row_k[NROW], row_win[NROW];

    s16_cen #(.BOARD(BOARD_V), .CPU_MODE(MODE_V)) DUT (
        .clk(clk), .clk_snd(clk_snd), .rst_n(rst_n),
        .pxl2_cen(pxl2_cen), .pxl_cen(pxl_cen), .cpu_cen(cpu_cen), .cpu_cenb(cpu_cenb),
        .mcu_cen(mcu_cen), .snd_cen(snd_cen), .fm_cen(fm_cen), .fm2_cen(fm2_cen),
        .pcm_cen(pcm_cen), .pcm_cenb(pcm_cenb)
    );

    cen_checker #(.CPU_MODE(MODE_V)) u_checker (.*);

    task automatic add_row(input int i, input cen_id_e rid, input logic rsnd,
                           input int rn, input int rm, input int rk, input int rwin);
        row_id[i]  = rid;
        row_snd[i] = rsnd;
        row_n[i]   = frac_t'(rn);
        row_m[i]   = frac_t'(rm);
        row_k[i]   = rk;
        row_win[i] = rwin;
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        clk_snd = 1'b0;
        forever #20 clk_snd = ~clk_snd;
    end

    initial begin
        int cpn, cpm, pn, pm, pwin;
        rst_n = 1'b0;
        start = 1'b0;
        snd_dom = 1'b0;
        id = PXL2;
        n = '0;
        m = frac_t'(1);
        k = 0;
        win = 0;
        limit = 0;
        cpn  = (MODE_V == CPU_FAST) ? 1 : `CPU_N;    // Toggle is one half
        cpm  = (MODE_V == CPU_FAST) ? 2 : `CPU_M;
        pn   = (BOARD_V == BOARD_B) ? `PCMB_N : `PCMA_N;
        pm   = (BOARD_V == BOARD_B) ? `PCMB_M : `PCMA_M;
        pwin = (BOARD_V == BOARD_B) ? 2000 : 400;    // Slow PCM needs a long window
        add_row(0, PXL2, 1'b0, `PXL_N, `PXL_M, 0, 400);
        add_row(1, PXL,  1'b0, `PXL_N, `PXL_M, 1, 400);
        add_row(2, CPU,  1'b0, cpn, cpm, 0, 600);
        add_row(3, CPUB, 1'b0, cpn, cpm, 0, 600);
        add_row(4, MCU,  1'b1, `MCU_N, `MCU_M, 0, 400);
        add_row(5, SND,  1'b1, `SND_N, `SND_M, 0, 500);
        add_row(6, FM,   1'b1, `FM_N, `FM_M, 0, 600);
        add_row(7, FM2,  1'b1, `FM_N, `FM_M, 1, 600);
        add_row(8, PCM,  1'b1, pn, pm, 0, pwin);
        add_row(9, PCMB, 1'b1, pn, pm, 0, pwin);
        for (int i = 0; i < NROW; i++) begin
            limit += row_snd[i] ? 2 * row_win[i] : row_win[i];
        end
        limit = 2 * limit + 100;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        for (int i = 0; i < NROW; i++) begin
            if (row_snd[i]) @(negedge clk_snd);
            else @(negedge clk);
            id      = row_id[i];
            snd_dom = row_snd[i];
            n       = row_n[i];
            m       = row_m[i];
            k       = row_k[i];
            win     = row_win[i];
            start   = 1'b1;
            if (row_snd[i]) @(negedge clk_snd);
            else @(negedge clk);
            start = 1'b0;
            wait (tests_done == i + 1);
        end
        $display("Tests passed %0d, failed %0d, other errors %0d",
                 pass_cnt, fail_cnt, err_cnt);
        if (fail_cnt == 0 && err_cnt == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    // Run limit from the total window length
    initial cyc = 0;
    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (limit > 0 && cyc >= limit) begin
            $display("Timeout: run stopped after %0d clk cycles", cyc);
            $display("FAIL: see errors above");
            $finish;
        end
    end

endmodule

//--- vlog.f
+incdir+common
common/board_pkg.sv
common/cen_pkg.sv
logic/frac_cen.sv
logic/s16_cen.sv
test/cen_checker.sv
test/tb_s16_cen.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

status=0

run_variant() {
    local name=$1 board=$2 mode=$3
    verilator --binary --timing -f vlog.f --top-module tb_s16_cen \
        -GBOARD="$board" -GCPU_MODE="$mode" -Mdir "build_$name" -o sim
    "./build_$name/sim" | tee "sim_$name.log"
    if grep -q "^PASS: all tests$" "sim_$name.log"; then
        echo "Variant $name passed"
    else
        echo "Variant $name failed"
        status=1
    fi
}

run_variant a_frac 0 0
run_variant b_fast 1 1
exit $status
